// File: include/memUnit_consts.svh
`ifndef MEMUNIT_CONSTS_SVH
`define MEMUNIT_CONSTS_SVH

// datapath and address widths
`define MEM_DATA_W   32
`define MEM_ADDR_W   10
`define MEM_PERIOD_W 10
`define MEM_DELAY_W  10
`define MEM_PORTS    2
// bus valid to ready, in cycles
`define MEM_RD_LAT   3

// configuration field select codes
`define CFG_FIELD_W  4
`define CFG_ITER     4'd0
`define CFG_PER      4'd1
`define CFG_DUTY     4'd2
`define CFG_START    4'd3
`define CFG_SHIFT    4'd4
`define CFG_INCR     4'd5
`define CFG_DELAY    4'd6
`define CFG_FLAGS    4'd7

// bit positions in the flags word
`define CFG_FLAG_REV  0
`define CFG_FLAG_EXT  1
`define CFG_FLAG_WREN 2

`endif

// File: hw/memUnitPkg.sv
`include "memUnit_consts.svh"

package memUnitPkg;

   // one RAM word and one RAM address
   typedef logic [`MEM_DATA_W-1:0]   dataT;
   typedef logic [`MEM_ADDR_W-1:0]   addrT;

   // generator counter widths
   typedef logic [`MEM_PERIOD_W-1:0] periodT;
   typedef logic [`MEM_DELAY_W-1:0]  delayT;

   // configuration port selects
   typedef logic [`CFG_FIELD_W-1:0]  cfgFieldT;
   typedef logic [0:0]               portIdxT;

   typedef enum logic [1:0] {
      genIdle,
      genDelay,
      genRun
   } genStateT;

endpackage

// File: hw/addrGenCfgIf.sv
`timescale 1ns/1ps

interface addrGenCfgIf;
   import memUnitPkg::*;

   // access pattern
   addrT   iterations;
   addrT   start;
   addrT   shift;
   addrT   incr;
   periodT period;
   periodT duty;
   delayT  delay;

   // port mode levels
   logic   reverse;
   logic   ext;
   logic   wrEn;

   modport bank (
      output iterations, start, shift, incr, period, duty, delay,
      output reverse, ext, wrEn
   );

   modport gen (
      input iterations, start, shift, incr, period, duty, delay
   );

   modport mem (
      input reverse, ext, wrEn
   );

endinterface

// File: hw/memPortIf.sv
`timescale 1ns/1ps

interface memPortIf;
   import memUnitPkg::*;

   addrT addr;
   // one access per high cycle
   logic en;
   // level, high while the generator is idle
   logic done;

   modport gen (
      output addr, en, done
   );

   modport mem (
      input addr, en
   );

endinterface

// File: hw/cfgRegBank.sv
`timescale 1ns/1ps
`include "memUnit_consts.svh"

module cfgRegBank (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cfgWr,
   input  memUnitPkg::portIdxT  cfgPort,
   input  memUnitPkg::cfgFieldT cfgField,
   input  memUnitPkg::dataT     cfgData,
   addrGenCfgIf.bank            cfg [0:`MEM_PORTS-1]
);
   import memUnitPkg::*;

   addrT   iterReg  [0:`MEM_PORTS-1];
   addrT   startReg [0:`MEM_PORTS-1];
   addrT   shiftReg [0:`MEM_PORTS-1];
   addrT   incrReg  [0:`MEM_PORTS-1];
   periodT perReg   [0:`MEM_PORTS-1];
   periodT dutyReg  [0:`MEM_PORTS-1];
   delayT  delayReg [0:`MEM_PORTS-1];
   logic   revReg   [0:`MEM_PORTS-1];
   logic   extReg   [0:`MEM_PORTS-1];
   logic   wrEnReg  [0:`MEM_PORTS-1];

   // one field of one port per strobe, data truncated to the field width
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int p = 0; p < `MEM_PORTS; p++) begin
            iterReg[p]  <= '0;
            startReg[p] <= '0;
            shiftReg[p] <= '0;
            incrReg[p]  <= '0;
            perReg[p]   <= '0;
            dutyReg[p]  <= '0;
            delayReg[p] <= '0;
            revReg[p]   <= 1'b0;
            extReg[p]   <= 1'b0;
            wrEnReg[p]  <= 1'b0;
         end
      end else if (cfgWr) begin
         case (cfgField)
            `CFG_ITER:  iterReg[cfgPort]  <= cfgData[`MEM_ADDR_W-1:0];
            `CFG_PER:   perReg[cfgPort]   <= cfgData[`MEM_PERIOD_W-1:0];
            `CFG_DUTY:  dutyReg[cfgPort]  <= cfgData[`MEM_PERIOD_W-1:0];
            `CFG_START: startReg[cfgPort] <= cfgData[`MEM_ADDR_W-1:0];
            `CFG_SHIFT: shiftReg[cfgPort] <= cfgData[`MEM_ADDR_W-1:0];
            `CFG_INCR:  incrReg[cfgPort]  <= cfgData[`MEM_ADDR_W-1:0];
            `CFG_DELAY: delayReg[cfgPort] <= cfgData[`MEM_DELAY_W-1:0];
            `CFG_FLAGS: begin
               // flags word unpacked into the three mode levels
               revReg[cfgPort]  <= cfgData[`CFG_FLAG_REV];
               extReg[cfgPort]  <= cfgData[`CFG_FLAG_EXT];
               wrEnReg[cfgPort] <= cfgData[`CFG_FLAG_WREN];
            end
            default: begin
            end
         endcase
      end
   end

   // drive each port's configuration interface
   for (genvar p = 0; p < `MEM_PORTS; p++) begin : gCfgOut
      assign cfg[p].iterations = iterReg[p];
      assign cfg[p].start      = startReg[p];
      assign cfg[p].shift      = shiftReg[p];
      assign cfg[p].incr       = incrReg[p];
      assign cfg[p].period     = perReg[p];
      assign cfg[p].duty       = dutyReg[p];
      assign cfg[p].delay      = delayReg[p];
      assign cfg[p].reverse    = revReg[p];
      assign cfg[p].ext        = extReg[p];
      assign cfg[p].wrEn       = wrEnReg[p];
   end

endmodule

// File: hw/addrGen.sv
`timescale 1ns/1ps
`include "memUnit_consts.svh"

module addrGen (
   input logic      clk,
   input logic      rst,
   input logic      run,
   addrGenCfgIf.gen cfg,
   memPortIf.gen    port
);
   import memUnitPkg::*;

   genStateT state;
   delayT    delayCnt;
   // cycle position inside the current period
   periodT   phase;
   // periods already completed
   addrT     iterCnt;
   addrT     curAddr;
   logic     doneReg;

   // one bit wider so that a zero period or iteration count still ends
   logic [`MEM_PERIOD_W:0] phaseNext;
   logic [`MEM_ADDR_W:0]   iterNext;
   logic                   inDuty;
   logic                   lastCycle;
   logic                   lastPeriod;
   addrT                   stepAddr;

   assign phaseNext  = {1'b0, phase} + 1'b1;
   assign iterNext   = {1'b0, iterCnt} + 1'b1;
   assign inDuty     = (phase < cfg.duty);
   assign lastCycle  = (phaseNext >= {1'b0, cfg.period});
   assign lastPeriod = (iterNext >= {1'b0, cfg.iterations});

   // address after this cycle, incr only counts on enabled cycles
   assign stepAddr = inDuty ? (curAddr + cfg.incr) : curAddr;

   assign port.en   = (state == genRun) && inDuty;
   assign port.addr = curAddr;
   assign port.done = doneReg;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= genIdle;
         delayCnt <= '0;
         phase    <= '0;
         iterCnt  <= '0;
         curAddr  <= '0;
         doneReg  <= 1'b1;
      end else begin
         case (state)
            genIdle: begin
               // run is only looked at here, a pulse while busy is dropped
               if (run) begin
                  doneReg  <= 1'b0;
                  phase    <= '0;
                  iterCnt  <= '0;
                  curAddr  <= cfg.start;
                  delayCnt <= cfg.delay;
                  if (cfg.delay == '0) begin
                     state <= genRun;
                  end else begin
                     state <= genDelay;
                  end
               end
            end

            genDelay: begin
               // counts delay down to one, then the first period starts
               delayCnt <= delayCnt - 1'b1;
               if (delayCnt == delayT'(1)) begin
                  state <= genRun;
               end
            end

            genRun: begin
               if (lastCycle) begin
                  phase   <= '0;
                  curAddr <= stepAddr + cfg.shift;
                  if (lastPeriod) begin
                     state   <= genIdle;
                     doneReg <= 1'b1;
                  end else begin
                     iterCnt <= iterNext[`MEM_ADDR_W-1:0];
                  end
               end else begin
                  phase   <= phaseNext[`MEM_PERIOD_W-1:0];
                  curAddr <= stepAddr;
               end
            end

            default: begin
               state <= genIdle;
            end
         endcase
      end
   end

endmodule

// File: hw/dualPortMem.sv
`timescale 1ns/1ps
`include "memUnit_consts.svh"

module dualPortMem (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     valid,
   input  logic [`MEM_DATA_W/8-1:0] wstrb,
   input  memUnitPkg::addrT         addr,
   input  memUnitPkg::dataT         wdata,
   output logic                     ready,
   output memUnitPkg::dataT         rdata,
   input  memUnitPkg::dataT         in0,
   input  memUnitPkg::dataT         in1,
   output memUnitPkg::dataT         out0,
   addrGenCfgIf.mem                 cfg  [0:`MEM_PORTS-1],
   memPortIf.mem                    port [0:`MEM_PORTS-1]
);
   import memUnitPkg::*;

   function automatic addrT reverseBits(input addrT word);
      addrT res;
      for (int i = 0; i < `MEM_ADDR_W; i++) begin
         res[i] = word[`MEM_ADDR_W-1-i];
      end
      return res;
   endfunction

   dataT                  inData  [0:`MEM_PORTS-1];
   addrT                  selAddr [0:`MEM_PORTS-1];
   logic [`MEM_PORTS-1:0] genWe;

   // port A after bus arbitration
   addrT addrA;
   dataT dataA;
   logic enA;
   logic weA;

   // input register stage
   addrT addrAReg;
   addrT addrBReg;
   dataT dataAReg;
   dataT dataBReg;
   logic enAReg;
   logic weAReg;
   logic weBReg;

   dataT ram [0:(1 << `MEM_ADDR_W)-1];
   dataT qA;
   logic rdValid;
   dataT outAReg;
   logic [`MEM_RD_LAT-1:0] vldPipe;

   assign inData[0] = in0;
   assign inData[1] = in1;

   // per port address select and generator write enable
   for (genvar p = 0; p < `MEM_PORTS; p++) begin : gSel
      addrT genAddr;
      assign genAddr    = cfg[p].reverse ? reverseBits(port[p].addr) : port[p].addr;
      // external addressing uses the low bits of the data input
      assign selAddr[p] = cfg[p].ext ? inData[p][`MEM_ADDR_W-1:0] : genAddr;
      // data input cannot be written while it is an address
      assign genWe[p]   = port[p].en & cfg[p].wrEn & ~cfg[p].ext;
   end

   // bus wins port A in the cycle it is valid
   assign addrA = valid ? addr : selAddr[0];
   assign dataA = valid ? wdata : in0;
   assign enA   = valid | port[0].en;
   assign weA   = valid ? (|wstrb) : genWe[0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         enAReg <= 1'b0;
         weAReg <= 1'b0;
         weBReg <= 1'b0;
      end else begin
         enAReg <= enA;
         weAReg <= weA;
         weBReg <= genWe[1];
      end
   end

   always_ff @(posedge clk) begin
      addrAReg <= addrA;
      addrBReg <= selAddr[1];
      dataAReg <= dataA;
      dataBReg <= in1;
   end

   // true dual port array, port A reads with one cycle latency
   always_ff @(posedge clk) begin
      if (weAReg) begin
         ram[addrAReg] <= dataAReg;
      end
      if (weBReg) begin
         ram[addrBReg] <= dataBReg;
      end
      if (enAReg && !weAReg) begin
         qA <= ram[addrAReg];
      end
   end

   // read tracking and bus ready shift
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rdValid <= 1'b0;
         vldPipe <= '0;
      end else begin
         rdValid <= enAReg & ~weAReg;
         vldPipe <= {vldPipe[`MEM_RD_LAT-2:0], valid};
      end
   end

   // output register holds until the next read lands
   always_ff @(posedge clk) begin
      if (rdValid) begin
         outAReg <= qA;
      end
   end

   assign ready = vldPipe[`MEM_RD_LAT-1];
   assign rdata = ready ? outAReg : '0;
   assign out0  = outAReg;

endmodule

// File: hw/memUnit.sv
`timescale 1ns/1ps
`include "memUnit_consts.svh"

module memUnit (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     run,
   output logic                     done,
   input  logic                     cfgWr,
   input  memUnitPkg::portIdxT      cfgPort,
   input  memUnitPkg::cfgFieldT     cfgField,
   input  memUnitPkg::dataT         cfgData,
   input  logic                     valid,
   input  logic [`MEM_DATA_W/8-1:0] wstrb,
   input  memUnitPkg::addrT         addr,
   input  memUnitPkg::dataT         wdata,
   output logic                     ready,
   output memUnitPkg::dataT         rdata,
   input  memUnitPkg::dataT         in0,
   input  memUnitPkg::dataT         in1,
   output memUnitPkg::dataT         out0
);

   logic [`MEM_PORTS-1:0] genDone;

   addrGenCfgIf cfgIf  [0:`MEM_PORTS-1] ();
   memPortIf    portIf [0:`MEM_PORTS-1] ();

   cfgRegBank cfgRegBank_inst (
      .clk      (clk),
      .rst      (rst),
      .cfgWr    (cfgWr),
      .cfgPort  (cfgPort),
      .cfgField (cfgField),
      .cfgData  (cfgData),
      .cfg      (cfgIf)
   );

   // port A generator at index 0, port B at index 1
   for (genvar g = 0; g < `MEM_PORTS; g++) begin : gGen
      addrGen addrGen_inst (
         .clk  (clk),
         .rst  (rst),
         .run  (run),
         .cfg  (cfgIf[g]),
         .port (portIf[g])
      );
      assign genDone[g] = portIf[g].done;
   end

   dualPortMem dualPortMem_inst (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .wstrb (wstrb),
      .addr  (addr),
      .wdata (wdata),
      .ready (ready),
      .rdata (rdata),
      .in0   (in0),
      .in1   (in1),
      .out0  (out0),
      .cfg   (cfgIf),
      .port  (portIf)
   );

   // unit is done only once both patterns have finished
   assign done = &genDone;

endmodule

// File: testbench/memUnitTb.sv
`timescale 1ns/1ps
`include "memUnit_consts.svh"

module memUnitTb;
   import memUnitPkg::*;

   localparam int NUM_ENTRIES = 6;
   // bus readback window and number of seeded words
   localparam int READ_SPAN   = 64;

   // flags in the configuration flags word layout
   typedef struct packed {
      addrT       iter;
      periodT     per;
      periodT     duty;
      addrT       start;
      addrT       shift;
      addrT       incr;
      delayT      delay;
      logic [2:0] flags;
   } portCfgT;

   typedef struct packed {
      portCfgT a;
      portCfgT b;
      logic    runIt;
      logic    checkA;
   } entryT;

   logic     clk;
   logic     rst;
   logic     run;
   logic     done;
   logic     cfgWr;
   portIdxT  cfgPort;
   cfgFieldT cfgField;
   dataT     cfgData;
   logic     valid;
   logic [`MEM_DATA_W/8-1:0] wstrb;
   addrT     addr;
   dataT     wdata;
   logic     ready;
   dataT     rdata;
   dataT     in0;
   dataT     in1;
   dataT     out0;

   entryT tbl [0:NUM_ENTRIES-1];
   dataT  model [0:(1 << `MEM_ADDR_W)-1];
   int    evM [$];
   addrT  evAddr [$];
   int    landM [$];
   dataT  landWord [$];
   int    seed = 41761;
   int    cycleCnt = 0;
   int    cycleLimit = 100000;

   memUnit memUnit_inst (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycleCnt <= cycleCnt + 1;
      if (cycleCnt >= cycleLimit) begin
         $display("Timeout: the run went past %0d clock cycles", cycleLimit);
         $display("Simulation failed");
         $fatal(1);
      end
   end

   task automatic reportError(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // mirror the address bits
   function automatic addrT flipAddr(input addrT a);
      addrT r;
      r = '0;
      for (int i = 0; i < `MEM_ADDR_W; i++) begin
         r = {r[`MEM_ADDR_W-2:0], a[i]};
      end
      return r;
   endfunction

   // stream word for run cycle m whose low bits double as an address
   function automatic dataT streamWord(input logic side, input int m);
      return {side ? 8'hB1 : 8'hA0, 14'h0, addrT'(m % READ_SPAN)};
   endfunction

   function automatic int patternEnd(input portCfgT c);
      return int'(c.delay) + int'(c.iter) * int'(c.per);
   endfunction

   task automatic writeCfg(input portIdxT p, input cfgFieldT f, input dataT d);
      @(negedge clk);
      cfgWr    = 1'b1;
      cfgPort  = p;
      cfgField = f;
      cfgData  = d;
   endtask

   task automatic loadPort(input portIdxT p, input portCfgT c);
      writeCfg(p, `CFG_ITER, dataT'(c.iter));
      writeCfg(p, `CFG_PER, dataT'(c.per));
      writeCfg(p, `CFG_DUTY, dataT'(c.duty));
      writeCfg(p, `CFG_START, dataT'(c.start));
      writeCfg(p, `CFG_SHIFT, dataT'(c.shift));
      writeCfg(p, `CFG_INCR, dataT'(c.incr));
      writeCfg(p, `CFG_DELAY, dataT'(c.delay));
      writeCfg(p, `CFG_FLAGS, dataT'(c.flags));
   endtask

   task automatic busAccess(input logic isWrite, input addrT a, input dataT d,
                            output dataT rd);
      int lat;
      @(negedge clk);
      assert (!ready) else reportError("ready was still high when a new access began");
      valid = 1'b1;
      wstrb = isWrite ? 4'hF : 4'h0;
      addr  = a;
      wdata = d;
      @(negedge clk);
      valid = 1'b0;
      lat   = 1;
      while (!ready && lat < 8) begin
         assert (rdata == '0) else reportError($sformatf("rdata %h with ready low", rdata));
         @(negedge clk);
         lat++;
      end
      assert (ready) else reportError("the bus access never returned ready");
      assert (lat == `MEM_RD_LAT)
         else reportError($sformatf("ready after %0d cycles, expected %0d", lat, `MEM_RD_LAT));
      rd = rdata;
   endtask

   task automatic busWrite(input addrT a, input dataT d);
      dataT rd;
      busAccess(1'b1, a, d, rd);
      model[a] = d;
   endtask

   task automatic busCheck(input addrT a);
      dataT rd;
      busAccess(1'b0, a, '0, rd);
      assert (rd == model[a])
         else reportError($sformatf("bus read at %0d gave %h, expected %h", a, rd, model[a]));
   endtask

   // enabled run cycles and their addresses from delay, period, duty and steps
   task automatic predict(input portCfgT c);
      addrT cur;
      evM.delete();
      evAddr.delete();
      cur = c.start;
      for (int i = 0; i < int'(c.iter); i++) begin
         for (int p = 0; p < int'(c.per); p++) begin
            if (p < int'(c.duty)) begin
               evM.push_back(1 + int'(c.delay) + i * int'(c.per) + p);
               evAddr.push_back(cur);
               cur = cur + c.incr;
            end
         end
         cur = cur + c.shift;
      end
   endtask

   // patterns of one entry touch disjoint addresses so B writes reach the model after the run
   task automatic runEntry(input entryT e);
      int   doneAt;
      int   endM;
      int   rdIdx;
      logic expDone;
      addrT ra;
      predict(e.a);
      landM.delete();
      landWord.delete();
      for (int k = 0; k < evM.size() && e.checkA; k++) begin
         if (e.a.flags[`CFG_FLAG_EXT]) begin
            ra = addrT'(streamWord(1'b0, evM[k]));
         end else begin
            ra = e.a.flags[`CFG_FLAG_REV] ? flipAddr(evAddr[k]) : evAddr[k];
         end
         landM.push_back(evM[k] + `MEM_RD_LAT);
         landWord.push_back(model[ra]);
      end
      predict(e.b);
      doneAt = 1 + ((patternEnd(e.a) > patternEnd(e.b)) ? patternEnd(e.a) : patternEnd(e.b));
      endM   = e.runIt ? doneAt + 2 : 8;
      if (landM.size() > 0 && landM[landM.size()-1] + 2 > endM) begin
         endM = landM[landM.size()-1] + 2;
      end
      rdIdx = 0;
      for (int m = 0; m <= endM; m++) begin
         @(negedge clk);
         expDone = !e.runIt || m == 0 || m >= doneAt;
         assert (done == expDone)
            else reportError($sformatf("done %b at run cycle %0d, expected %b", done, m, expDone));
         if (rdIdx < landM.size() && landM[rdIdx] == m) begin
            assert (out0 == landWord[rdIdx])
               else reportError($sformatf("out0 %h at run cycle %0d, expected %h",
                                          out0, m, landWord[rdIdx]));
            rdIdx++;
         end
         run = e.runIt && m == 0;
         in0 = streamWord(1'b0, m);
         in1 = streamWord(1'b1, m);
      end
      if (e.runIt && e.b.flags[`CFG_FLAG_WREN] && !e.b.flags[`CFG_FLAG_EXT]) begin
         for (int k = 0; k < evM.size(); k++) begin
            ra = e.b.flags[`CFG_FLAG_REV] ? flipAddr(evAddr[k]) : evAddr[k];
            model[ra] = streamWord(1'b1, evM[k]);
         end
      end
   endtask

   initial begin
      int total;
      // B stream write, A read, A reversed, ext on both, done from A, no run
      tbl[0] = '{'{1, 1, 0, 0, 0, 0, 0, 0}, '{4, 3, 3, 8, 2, 1, 2, 4}, 1'b1, 1'b0};
      tbl[1] = '{'{3, 5, 3, 4, 3, 2, 1, 0}, '{3, 6, 1, 0, 0, 0, 4, 0}, 1'b1, 1'b1};
      tbl[2] = '{'{3, 5, 3, 4, 3, 2, 1, 1}, '{1, 1, 0, 0, 0, 0, 0, 0}, 1'b1, 1'b1};
      tbl[3] = '{'{2, 4, 4, 0, 0, 1, 0, 2}, '{2, 3, 3, 30, 1, 1, 3, 6}, 1'b1, 1'b1};
      tbl[4] = '{'{2, 4, 2, 0, 1, 3, 7, 0}, '{2, 5, 2, 50, 4, 1, 0, 4}, 1'b1, 1'b1};
      tbl[5] = '{'{2, 2, 2, 0, 1, 1, 0, 0}, '{4, 3, 3, 0, 0, 1, 0, 4}, 1'b0, 1'b0};
      total = 4 * READ_SPAN;
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         total += 29 + READ_SPAN + patternEnd(tbl[e].a) + patternEnd(tbl[e].b);
      end
      cycleLimit = total * 4 + 200;
      rst      = 1'b1;
      run      = 1'b0;
      cfgWr    = 1'b0;
      cfgPort  = '0;
      cfgField = '0;
      cfgData  = '0;
      valid    = 1'b0;
      wstrb    = '0;
      addr     = '0;
      wdata    = '0;
      in0      = '0;
      in1      = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      assert (done) else reportError("done is low after reset");
      // seed the low window and its bit-reversed image
      for (int i = 0; i < READ_SPAN; i++) begin
         busWrite(addrT'(i), dataT'($random(seed)));
         busWrite(flipAddr(addrT'(i)), dataT'($random(seed)));
      end
      for (int i = 0; i < READ_SPAN; i++) begin
         busCheck(addrT'(i));
         busCheck(flipAddr(addrT'(i)));
      end
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         loadPort(1'b0, tbl[e].a);
         loadPort(1'b1, tbl[e].b);
         @(negedge clk);
         cfgWr = 1'b0;
         runEntry(tbl[e]);
         for (int i = 0; i < READ_SPAN; i++) begin
            busCheck(addrT'(i));
         end
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: sources.f
+incdir+include
hw/memUnitPkg.sv
hw/addrGenCfgIf.sv
hw/memPortIf.sv
hw/cfgRegBank.sv
hw/addrGen.sv
hw/dualPortMem.sv
hw/memUnit.sv
testbench/memUnitTb.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line
verilator --binary --timing --assert -f sources.f --top-module memUnitTb -o memUnitSim \
   || { echo "build failed"; exit 1; }
./obj_dir/memUnitSim > sim.log 2>&1
grep -qx "Simulation completed successfully" sim.log && echo "PASS" \
   || { echo "FAIL, see sim.log"; exit 1; }
